//--- dv/tb_clk_gen.sv
/*
 * Clock and reset source for the crossbar testbench.
 * Free-running clock of PERIOD_NS; reset held low for RESET_CYC rising
 * edges and released on a falling edge, away from the sampling edge.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen
#(
    parameter realtime     PERIOD_NS = 8.0,
    parameter int unsigned RESET_CYC = 8
)
(
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (RESET_CYC) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- dv/tb_mem_slave.sv
/*
 * Behavioral memory slave for the crossbar testbench.
 * Grants whenever gnt_en_i is high (random pattern from the testbench
 * top) and answers every transfer one cycle later with the received ID.
 * Byte offsets at or above 0x800 within the range answer with opc set.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_mem_slave
    import xbar_pkg::*;
#(
    parameter int unsigned SLV_IDX = 0
)
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       gnt_en_i,
    input  wire logic       s_req_i,
    input  wire req_t       s_payload_i,
    input  wire master_id_t s_id_i,
    output logic            s_gnt_o,
    output logic            s_r_valid_o,
    output master_id_t      s_r_id_o,
    output resp_t           s_r_resp_o
);

    localparam int unsigned WORDS = (SLAVE_END[SLV_IDX] - SLAVE_START[SLV_IDX]) / BE_W;
    localparam logic [ADDR_W-1:0] ERR_OFS = 32'h0000_0800;

    logic [DATA_W-1:0] mem [WORDS];
    logic [ADDR_W-1:0] ofs;  // Byte offset inside the range

    assign s_gnt_o = gnt_en_i;
    assign ofs     = s_payload_i.addr - SLAVE_START[SLV_IDX];

    initial
    begin
        for (int unsigned i = 0; i < WORDS; i++)
            mem[i] = '0;
    end

    always @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            s_r_valid_o <= 1'b0;
            s_r_id_o    <= '0;
            s_r_resp_o  <= '0;
        end
        else
        begin
            s_r_valid_o <= 1'b0;  // One-cycle pulse
            if (s_req_i && s_gnt_o)
            begin
                s_r_valid_o      <= 1'b1;
                s_r_id_o         <= s_id_i;
                s_r_resp_o.rdata <= '0;
                s_r_resp_o.opc   <= 1'b0;
                if (ofs >= ERR_OFS)
                    s_r_resp_o.opc <= 1'b1;  // Upper half is off limits
                else if (s_payload_i.wen)
                    s_r_resp_o.rdata <= mem[ofs >> 2];
                else
                begin
                    for (int unsigned b = 0; b < BE_W; b++)
                    begin
                        if (s_payload_i.be[b])
                            mem[ofs >> 2][8*b +: 8] <= s_payload_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_xbar_bridge.sv
/*
 * Testbench top for the bridge crossbar.
 * Random masters issue loads and stores to disjoint words; a reference
 * memory per slave predicts every response. Routing, grants, response
 * delivery, error flags and round-robin fairness are checked each cycle.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_xbar_bridge
    import xbar_pkg::*;
;

    localparam int unsigned NUM_REQ     = 300;
    localparam int unsigned BURST_REQ   = 40;   // Opening burst on slave 0
    localparam int unsigned RESET_CYC   = 8;
    localparam int unsigned TIMEOUT_CYC = NUM_REQ * N_MASTER * 8 + RESET_CYC;
    localparam int unsigned MEM_WORDS   = (SLAVE_END[0] - SLAVE_START[0]) / BE_W;
    localparam int unsigned ERR_OFS     = 'h800;
    localparam int unsigned RING        = 8;
    localparam logic [31:0] SEED        = 32'heb0bf754;

    logic clk;
    logic rst_n;

    logic       [N_MASTER-1:0] m_req;
    req_t       [N_MASTER-1:0] m_payload;
    logic       [N_MASTER-1:0] m_gnt;
    logic       [N_MASTER-1:0] m_r_valid;
    resp_t      [N_MASTER-1:0] m_r_resp;
    logic       [N_SLAVE-1:0]  s_req;
    req_t       [N_SLAVE-1:0]  s_payload;
    master_id_t [N_SLAVE-1:0]  s_id;
    logic       [N_SLAVE-1:0]  s_gnt;
    logic       [N_SLAVE-1:0]  s_gnt_en;
    logic       [N_SLAVE-1:0]  s_r_valid;
    master_id_t [N_SLAVE-1:0]  s_r_id;
    resp_t      [N_SLAVE-1:0]  s_r_resp;

    logic [DATA_W-1:0] ref_mem [N_SLAVE][MEM_WORDS];
    resp_t             exp_buf [N_MASTER][RING];  // Expected responses in issue order
    int unsigned       wr_ptr [N_MASTER];
    int unsigned       rd_ptr [N_MASTER];
    int unsigned       issued [N_MASTER];
    int unsigned       received [N_MASTER];
    int unsigned       gap [N_MASTER];
    int unsigned       waits [N_MASTER];
    int unsigned       errors;
    int unsigned       checks;
    int unsigned       cycle;

    tb_clk_gen #(.PERIOD_NS(8.0), .RESET_CYC(RESET_CYC)) u_tb_clk_gen
    (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    xbar_bridge u_xbar_bridge
    (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .m_req_i     ( m_req     ),
        .m_payload_i ( m_payload ),
        .m_gnt_o     ( m_gnt     ),
        .m_r_valid_o ( m_r_valid ),
        .m_r_resp_o  ( m_r_resp  ),
        .s_req_o     ( s_req     ),
        .s_payload_o ( s_payload ),
        .s_id_o      ( s_id      ),
        .s_gnt_i     ( s_gnt     ),
        .s_r_valid_i ( s_r_valid ),
        .s_r_id_i    ( s_r_id    ),
        .s_r_resp_i  ( s_r_resp  )
    );

    for (genvar j = 0; j < N_SLAVE; j++)
    begin : g_mem
        tb_mem_slave #(.SLV_IDX(j)) u_tb_mem_slave
        (
            .clk_i       ( clk          ),
            .rst_n_i     ( rst_n        ),
            .gnt_en_i    ( s_gnt_en[j]  ),
            .s_req_i     ( s_req[j]     ),
            .s_payload_i ( s_payload[j] ),
            .s_id_i      ( s_id[j]      ),
            .s_gnt_o     ( s_gnt[j]     ),
            .s_r_valid_o ( s_r_valid[j] ),
            .s_r_id_o    ( s_r_id[j]    ),
            .s_r_resp_o  ( s_r_resp[j]  )
        );
    end

    function automatic int slave_of(input logic [ADDR_W-1:0] addr);
        int s;
        s = -1;
        for (int j = 0; j < N_SLAVE; j++)
        begin
            if (addr >= SLAVE_START[j] && addr < SLAVE_END[j])
                s = j;
        end
        return s;
    endfunction

    // Word index modulo N_MASTER equals k, so masters never share a word
    function automatic req_t random_request(input int unsigned k, input bit burst);
        req_t        r;
        int unsigned j;
        int unsigned w;
        j       = burst ? 0 : $urandom % N_SLAVE;
        w       = ($urandom % 16) * (MEM_WORDS / 16) + k;
        r.addr  = SLAVE_START[j] + w * BE_W;
        r.wen   = $urandom % 2;
        r.wdata = $urandom;
        r.be    = BE_W'($urandom % ((1 << BE_W) - 1) + 1);  // Never zero
        return r;
    endfunction

    task automatic check_routing();
        int unsigned hits;
        int unsigned who;
        logic        exp_req;
        for (int j = 0; j < N_SLAVE; j++)
        begin
            exp_req = 1'b0;
            for (int unsigned k = 0; k < N_MASTER; k++)
            begin
                if (m_req[k] && slave_of(m_payload[k].addr) == j)
                    exp_req = 1'b1;
            end
            checks++;
            if (s_req[j] != exp_req)
            begin
                errors++;
                $display("CHECK FAILED s_req_o[%0d]: got %h expected %h",
                         j, s_req[j], exp_req);
            end
            if (s_req[j] && s_gnt[j])
            begin
                hits = 0;
                who  = 0;
                for (int unsigned k = 0; k < N_MASTER; k++)
                begin
                    if (m_req[k] && slave_of(m_payload[k].addr) == j &&
                        m_payload[k] == s_payload[j])
                    begin
                        hits++;
                        who = k;
                    end
                end
                checks++;
                if (hits != 1)
                begin
                    errors++;
                    $display("ERROR: slave %0d payload matches %0d requesting masters", j, hits);
                end
                else if (s_id[j] != master_id_t'(1 << who))
                begin
                    errors++;
                    $display("CHECK FAILED s_id_o[%0d]: got %h expected %h",
                             j, s_id[j], master_id_t'(1 << who));
                end
                else if (!m_gnt[who])
                begin
                    errors++;
                    $display("CHECK FAILED m_gnt_o[%0d]: got %h expected %h",
                             who, m_gnt[who], 1'b1);
                end
            end
        end
    endtask

    task automatic check_responses();
        logic  want;
        resp_t exp;
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            want = 1'b0;
            for (int j = 0; j < N_SLAVE; j++)
            begin
                if (s_r_valid[j] && s_r_id[j][k])
                    want = 1'b1;
            end
            checks++;
            if (m_r_valid[k] != want)
            begin
                errors++;
                $display("CHECK FAILED m_r_valid_o[%0d]: got %h expected %h",
                         k, m_r_valid[k], want);
            end
            if (m_r_valid[k] && rd_ptr[k] == wr_ptr[k])
            begin
                errors++;
                $display("ERROR: master %0d got a response with nothing outstanding", k);
            end
            else if (m_r_valid[k])
            begin
                exp = exp_buf[k][rd_ptr[k] % RING];
                rd_ptr[k]++;
                received[k]++;
                checks++;
                if (m_r_resp[k] != exp)
                begin
                    errors++;
                    $display("CHECK FAILED m_r_resp_o[%0d]: got %h expected %h",
                             k, m_r_resp[k], exp);
                end
            end
        end
    endtask

    // Model update at each grant, plus back-pressure and fairness checks
    task automatic track_grants();
        int          j;
        int unsigned ofs;
        resp_t       exp;
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            j = slave_of(m_payload[k].addr);
            checks++;
            if (m_gnt[k] && (!m_req[k] || j < 0 || !s_gnt[j]))
            begin
                errors++;
                $display("CHECK FAILED m_gnt_o[%0d]: got %h expected %h", k, m_gnt[k], 1'b0);
            end
            else if (m_req[k] && m_gnt[k])
            begin
                ofs = m_payload[k].addr - SLAVE_START[j];
                exp = '0;
                if (ofs >= ERR_OFS)
                    exp.opc = 1'b1;  // Store dropped, load reads zero
                else if (m_payload[k].wen)
                    exp.rdata = ref_mem[j][ofs >> 2];
                else
                begin
                    for (int unsigned b = 0; b < BE_W; b++)
                    begin
                        if (m_payload[k].be[b])
                            ref_mem[j][ofs >> 2][8*b +: 8] = m_payload[k].wdata[8*b +: 8];
                    end
                end
                if (wr_ptr[k] - rd_ptr[k] >= RING)
                begin
                    errors++;
                    $display("ERROR: master %0d has too many responses outstanding", k);
                end
                exp_buf[k][wr_ptr[k] % RING] = exp;
                wr_ptr[k]++;
                issued[k]++;
                waits[k] = 0;
            end
            else if (m_req[k] && s_req[j] && s_gnt[j])
            begin
                waits[k]++;  // Another master took this slave
                if (waits[k] > N_MASTER - 1)
                begin
                    errors++;
                    $display("ERROR: master %0d waited through %0d transfers on slave %0d",
                             k, waits[k], j);
                end
            end
        end
    endtask

    task automatic drive_inputs();
        bit burst;
        for (int j = 0; j < N_SLAVE; j++)
            s_gnt_en[j] <= ($urandom % 10) < 7;
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            if (!(m_req[k] && !m_gnt[k]))  // Held requests stay untouched
            begin
                if (issued[k] >= NUM_REQ)
                    m_req[k] <= 1'b0;
                else if (gap[k] > 0)
                begin
                    gap[k]--;
                    m_req[k] <= 1'b0;
                end
                else
                begin
                    burst = issued[k] < BURST_REQ;
                    m_req[k]     <= 1'b1;
                    m_payload[k] <= random_request(k, burst);
                    gap[k]        = burst ? 0 : $urandom % 4;
                end
            end
        end
    endtask

    function automatic bit all_done();
        bit done;
        done = 1'b1;
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            if (issued[k] < NUM_REQ || rd_ptr[k] != wr_ptr[k] || m_req[k])
                done = 1'b0;
        end
        return done;
    endfunction

    initial
    begin
        m_req     = '0;
        m_payload = '0;
        s_gnt_en  = '0;
        errors    = 0;
        checks    = 0;
        cycle     = 0;
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            wr_ptr[k]   = 0;
            rd_ptr[k]   = 0;
            issued[k]   = 0;
            received[k] = 0;
            gap[k]      = 0;
            waits[k]    = 0;
        end
        for (int j = 0; j < N_SLAVE; j++)
            for (int unsigned w = 0; w < MEM_WORDS; w++)
                ref_mem[j][w] = '0;
        void'($urandom(SEED));
        @(posedge rst_n);
        while (!all_done() && cycle < TIMEOUT_CYC)
        begin
            @(posedge clk);
            cycle++;
            check_routing();
            check_responses();
            track_grants();
            drive_inputs();
        end
        if (!all_done())
        begin
            errors++;
            $display("ERROR: timeout after %0d cycles, requests still outstanding", cycle);
        end
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            checks++;
            if (received[k] != issued[k])
            begin
                errors++;
                $display("ERROR: master %0d got %0d responses for %0d grants",
                         k, received[k], issued[k]);
            end
        end
        $display("Run finished after %0d cycles: %0d errors in %0d checks", cycle, errors, checks);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/xbar_pkg.sv
verilog/rr_arbiter.sv
verilog/slave_port.sv
verilog/master_port.sv
verilog/xbar_bridge.sv
dv/tb_clk_gen.sv
dv/tb_mem_slave.sv
dv/tb_xbar_bridge.sv

//--- verilog/master_port.sv
/*
 * Master side of the crossbar for one master.
 * Decodes the request address against the fixed slave map, raises the
 * request toward the matching slave only, and returns that slave's grant.
 * On the way back it picks the response of the slave that answered.
 * Purely combinational.
 */

`timescale 1ns/100ps
`default_nettype none

module master_port
    import xbar_pkg::*;
(
    // Master interface
    input  wire logic                     req_i,
    input  wire req_t                     payload_i,
    output logic                          gnt_o,
    output logic                          r_valid_o,
    output resp_t                         r_resp_o,

    // One bit per slave toward the slave ports
    output logic          [N_SLAVE-1:0]   slv_req_o,
    input  wire logic     [N_SLAVE-1:0]   slv_gnt_i,
    input  wire logic     [N_SLAVE-1:0]   slv_r_valid_i,
    input  wire resp_t    [N_SLAVE-1:0]   slv_r_resp_i
);

    logic [N_SLAVE-1:0] dest_oh;  // Decoded destination

    // Address decode over non-overlapping ranges
    always_comb
    begin
        dest_oh = '0;
        for (int unsigned x = 0; x < N_SLAVE; x++)
        begin
            if ((payload_i.addr >= SLAVE_START[x]) &&
                (payload_i.addr <  SLAVE_END[x]))
            begin
                dest_oh[x] = 1'b1;
            end
        end
    end

    // Unmapped address raises no request and is never granted
    assign slv_req_o = dest_oh & {N_SLAVE{req_i}};

    assign gnt_o = |(slv_gnt_i & dest_oh);

    // At most one slave answers a master per cycle
    assign r_valid_o = |slv_r_valid_i;

    always_comb
    begin
        r_resp_o = '0;
        for (int unsigned x = 0; x < N_SLAVE; x++)
        begin
            if (slv_r_valid_i[x])
                r_resp_o = slv_r_resp_i[x];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rr_arbiter.sv
/*
 * Round-robin arbiter over the master requests of one slave.
 * Grant is combinational from the requests. The priority pointer moves
 * one past the winner on each transfer, so a waiting master is served
 * within N_MASTER transfers. Pointer resets to master 0.
 */

`timescale 1ns/100ps
`default_nettype none

module rr_arbiter
    import xbar_pkg::*;
(
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic [N_MASTER-1:0] req_i,
    input  wire logic                advance_i,  // Transfer this cycle
    output logic      [N_MASTER-1:0] gnt_o       // One-hot
);

    logic [IDX_W-1:0] ptr_q;     // Highest priority master
    logic [IDX_W-1:0] win_idx;
    logic [IDX_W-1:0] next_ptr;
    logic             found;

    // Search starting at the pointer, wrapping around
    always_comb
    begin
        gnt_o   = '0;
        win_idx = ptr_q;
        found   = 1'b0;
        for (int unsigned i = 0; i < N_MASTER; i++)
        begin
            if (!found && req_i[(ptr_q + i) % N_MASTER])
            begin
                found   = 1'b1;
                win_idx = IDX_W'((ptr_q + i) % N_MASTER);
            end
        end
        if (found)
            gnt_o[win_idx] = 1'b1;
    end

    assign next_ptr = (win_idx == IDX_W'(N_MASTER - 1)) ? '0 : win_idx + 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ptr_q <= '0;
        end
        else if (advance_i)
        begin
            ptr_q <= next_ptr;  // Winner drops to lowest priority
        end
    end

endmodule

`default_nettype wire

//--- verilog/slave_port.sv
/*
 * Request side of one slave lane.
 * Arbitrates the master requests aimed at this slave, forwards the
 * winner's payload tagged with its one-hot ID, and passes the slave grant
 * back to the winner only. The response valid is fanned out by ID.
 */

`timescale 1ns/100ps
`default_nettype none

module slave_port
    import xbar_pkg::*;
(
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,

    // From the master ports
    input  wire logic       [N_MASTER-1:0] req_i,
    input  wire req_t       [N_MASTER-1:0] payload_i,
    output logic            [N_MASTER-1:0] gnt_o,

    // Toward the slave
    output logic                         s_req_o,
    output req_t                         s_payload_o,
    output master_id_t                   s_id_o,
    input  wire logic                    s_gnt_i,

    // Response valid back to the masters
    input  wire logic                    s_r_valid_i,
    input  wire master_id_t              s_r_id_i,
    output logic            [N_MASTER-1:0] r_valid_o
);

    logic [N_MASTER-1:0] arb_gnt;
    logic                arb_advance;

    // Pointer only moves when a request actually transfers
    assign arb_advance = s_req_o & s_gnt_i;

    rr_arbiter u_rr_arbiter
    (
        .clk_i     ( clk_i       ),
        .rst_n_i   ( rst_n_i     ),
        .req_i     ( req_i       ),
        .advance_i ( arb_advance ),
        .gnt_o     ( arb_gnt     )
    );

    assign s_req_o = |req_i;

    // Winner's one-hot grant doubles as its ID
    assign s_id_o = master_id_t'(arb_gnt);

    // Payload mux on the one-hot winner
    always_comb
    begin
        s_payload_o = '0;
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            if (arb_gnt[k])
                s_payload_o = payload_i[k];
        end
    end

    // Back-pressure reaches only the selected master
    assign gnt_o = arb_gnt & {N_MASTER{s_gnt_i}};

    // Response routed by the ID returned from the slave
    assign r_valid_o = s_r_id_i & {N_MASTER{s_r_valid_i}};

endmodule

`default_nettype wire

//--- verilog/xbar_bridge.sv
/*
 * Top of the single-channel bridge crossbar.
 * N_MASTER master ports decode and steer requests, N_SLAVE slave ports
 * arbitrate them round-robin. Request, grant and response paths are all
 * combinational; only the arbiter pointers hold state.
 */

`timescale 1ns/100ps
`default_nettype none

module xbar_bridge
    import xbar_pkg::*;
(
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,

    // Master side
    input  wire logic       [N_MASTER-1:0]   m_req_i,
    input  wire req_t       [N_MASTER-1:0]   m_payload_i,
    output logic            [N_MASTER-1:0]   m_gnt_o,
    output logic            [N_MASTER-1:0]   m_r_valid_o,
    output resp_t           [N_MASTER-1:0]   m_r_resp_o,

    // Slave side
    output logic            [N_SLAVE-1:0]    s_req_o,
    output req_t            [N_SLAVE-1:0]    s_payload_o,
    output master_id_t      [N_SLAVE-1:0]    s_id_o,
    input  wire logic       [N_SLAVE-1:0]    s_gnt_i,
    input  wire logic       [N_SLAVE-1:0]    s_r_valid_i,
    input  wire master_id_t [N_SLAVE-1:0]    s_r_id_i,
    input  wire resp_t      [N_SLAVE-1:0]    s_r_resp_i
);

    // Master-major view
    logic [N_MASTER-1:0][N_SLAVE-1:0] mst_req;
    logic [N_MASTER-1:0][N_SLAVE-1:0] mst_gnt;
    logic [N_MASTER-1:0][N_SLAVE-1:0] mst_r_valid;

    // Slave-major view
    logic [N_SLAVE-1:0][N_MASTER-1:0] slv_req;
    logic [N_SLAVE-1:0][N_MASTER-1:0] slv_gnt;
    logic [N_SLAVE-1:0][N_MASTER-1:0] slv_r_valid;

    for (genvar k = 0; k < N_MASTER; k++)
    begin : g_transpose
        for (genvar j = 0; j < N_SLAVE; j++)
        begin : g_slv
            assign slv_req[j][k]     = mst_req[k][j];
            assign mst_gnt[k][j]     = slv_gnt[j][k];
            assign mst_r_valid[k][j] = slv_r_valid[j][k];
        end
    end

    for (genvar k = 0; k < N_MASTER; k++)
    begin : g_master
        master_port u_master_port
        (
            .req_i         ( m_req_i[k]      ),
            .payload_i     ( m_payload_i[k]  ),
            .gnt_o         ( m_gnt_o[k]      ),
            .r_valid_o     ( m_r_valid_o[k]  ),
            .r_resp_o      ( m_r_resp_o[k]   ),
            .slv_req_o     ( mst_req[k]      ),
            .slv_gnt_i     ( mst_gnt[k]      ),
            .slv_r_valid_i ( mst_r_valid[k]  ),
            .slv_r_resp_i  ( s_r_resp_i      )  // Every master sees all slaves
        );
    end

    for (genvar j = 0; j < N_SLAVE; j++)
    begin : g_slave
        slave_port u_slave_port
        (
            .clk_i       ( clk_i          ),
            .rst_n_i     ( rst_n_i        ),
            .req_i       ( slv_req[j]     ),
            .payload_i   ( m_payload_i    ),
            .gnt_o       ( slv_gnt[j]     ),
            .s_req_o     ( s_req_o[j]     ),
            .s_payload_o ( s_payload_o[j] ),
            .s_id_o      ( s_id_o[j]      ),
            .s_gnt_i     ( s_gnt_i[j]     ),
            .s_r_valid_i ( s_r_valid_i[j] ),
            .s_r_id_i    ( s_r_id_i[j]    ),
            .r_valid_o   ( slv_r_valid[j] )
        );
    end

endmodule

`default_nettype wire

//--- verilog/xbar_pkg.sv
/*
 * Shared sizes, address map and payload types of the bridge crossbar.
 * Compile this package before any RTL or testbench file; modules pull
 * it in through a wildcard import in their header.
 * The address map is fixed here, with one start/end pair per slave.
 */

`default_nettype none

package xbar_pkg;

    localparam int unsigned N_MASTER = 4;
    localparam int unsigned N_SLAVE  = 3;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // One bit per master in the ID
    localparam int unsigned ID_W  = N_MASTER;
    localparam int unsigned IDX_W = (N_MASTER > 1) ? $clog2(N_MASTER) : 1;

    // Slave j owns [SLAVE_START[j], SLAVE_END[j])
    localparam logic [N_SLAVE-1:0][ADDR_W-1:0] SLAVE_START = {
        32'h1000_0000,  // Slave 2
        32'h0001_0000,  // Slave 1
        32'h0000_0000   // Slave 0
    };

    localparam logic [N_SLAVE-1:0][ADDR_W-1:0] SLAVE_END = {
        32'h1000_1000,
        32'h0001_1000,
        32'h0000_1000
    };

    typedef logic [ID_W-1:0] master_id_t;

    // Request payload, held stable by the master until granted
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              wen;    // 1 load, 0 store
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } req_t;

    // Response payload, valid alongside r_valid
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              opc;    // Error flag
    } resp_t;

endpackage

`default_nettype wire
